/* ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

`define CTRL_XLEN 64
`define CTRL_ILEN 32

// Opcodes as this core encodes them
`define CTRL_OP_R     7'b0110011
`define CTRL_OP_I     7'b0010011
`define CTRL_OP_LOAD  7'b0000011
`define CTRL_OP_STORE 7'b0100011
`define CTRL_OP_BEQ   7'b1100011
`define CTRL_OP_BRJ   7'b1100111 // jalr, bne, bge and blt
`define CTRL_OP_LUI   7'b0110111
`define CTRL_OP_JAL   7'b1101111
`define CTRL_OP_NOP   7'b0000000

`define CTRL_F7_BASE 7'b0000000
`define CTRL_F7_SUB  7'b0100000

`define CTRL_ALU_PASS 3'd0
`define CTRL_ALU_ADD  3'd1
`define CTRL_ALU_SUB  3'd2
`define CTRL_ALU_AND  3'd3
`define CTRL_ALU_CMP  3'd7

`define CTRL_PC_SEQ    2'd0
`define CTRL_PC_TARGET 2'd1 // From ALUOut
`define CTRL_PC_EXC    2'd2

// Size codes shared by loads and stores
`define CTRL_SZ_NONE 3'd0
`define CTRL_SZ_D    3'd1
`define CTRL_SZ_W    3'd2
`define CTRL_SZ_H    3'd3
`define CTRL_SZ_B    3'd4
`define CTRL_SZ_WU   3'd5
`define CTRL_SZ_HU   3'd6
`define CTRL_SZ_BU   3'd7

`endif

/* ctrlPkg.sv */
`default_nettype none

`include "ctrl_consts.svh"

package ctrlPkg;

	typedef logic [`CTRL_ILEN-1:0] instr_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [2:0] muxSel_t;
	typedef logic [1:0] pcSel_t;
	typedef logic [2:0] memSize_t;

	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAnd, clsSlt,
		clsAddi, clsSlti,
		clsLd, clsLw, clsLh, clsLb, clsLwu, clsLhu, clsLbu,
		clsSd, clsSw, clsSh, clsSb,
		clsBeq, clsBne, clsBge, clsBlt,
		clsLui, clsJal, clsJalr,
		clsNop,
		clsIllegal
	} instrClass_t;

	typedef enum logic [4:0] {
		stReset,
		stFetch,
		stDecode,
		stAluExec,
		stImmExec,
		stWriteBack,
		stLoadAddr,
		stLoadWait1,
		stLoadWait2,
		stLoadWrite,
		stStoreAddr,
		stStoreWrite,
		stBeq,
		stBne,
		stBge,
		stBlt,
		stLui,
		stJalLink,
		stJalJump,
		stJalrLink,
		stJalrJump,
		stExc1,
		stExc2,
		stExc3,
		stNop // Idle cycle of a nop
	} ctrlState_t;

endpackage

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module instrDecoder (
	input wire ctrlPkg::instr_t instr,
	output ctrlPkg::instrClass_t cls,
	output ctrlPkg::memSize_t memSize,
	output ctrlPkg::aluOp_t aluFunc
);
	import ctrlPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		cls = clsIllegal;
		case (opcode)
			`CTRL_OP_NOP: begin
				if (instr == '0)
					cls = clsNop;
			end
			`CTRL_OP_R: begin
				if (funct7 == `CTRL_F7_SUB) begin
					cls = clsSub; // funct3 not checked
				end else if (funct7 == `CTRL_F7_BASE) begin
					case (funct3)
						3'b000: cls = clsAdd;
						3'b111: cls = clsAnd;
						3'b010: cls = clsSlt;
						default: cls = clsIllegal;
					endcase
				end
			end
			`CTRL_OP_I: begin
				case (funct3)
					3'b000: cls = clsAddi;
					3'b010: cls = clsSlti;
					default: cls = clsIllegal; // Shifts unsupported
				endcase
			end
			`CTRL_OP_LOAD: begin
				case (funct3)
					3'b000: cls = clsLb;
					3'b001: cls = clsLh;
					3'b010: cls = clsLw;
					3'b011: cls = clsLd;
					3'b100: cls = clsLbu;
					3'b101: cls = clsLhu;
					3'b110: cls = clsLwu;
					default: cls = clsIllegal;
				endcase
			end
			`CTRL_OP_STORE: begin
				case (funct3)
					3'b111: cls = clsSd; // Not the standard sd encoding
					3'b010: cls = clsSw;
					3'b001: cls = clsSh;
					3'b000: cls = clsSb;
					default: cls = clsIllegal;
				endcase
			end
			`CTRL_OP_BEQ: cls = clsBeq;
			`CTRL_OP_BRJ: begin
				case (funct3)
					3'b000: cls = clsJalr;
					3'b001: cls = clsBne;
					3'b101: cls = clsBge;
					3'b100: cls = clsBlt;
					default: cls = clsIllegal;
				endcase
			end
			`CTRL_OP_LUI: cls = clsLui;
			`CTRL_OP_JAL: cls = clsJal;
			default: cls = clsIllegal;
		endcase
	end

	always_comb begin
		case (cls)
			clsLd, clsSd: memSize = `CTRL_SZ_D;
			clsLw, clsSw: memSize = `CTRL_SZ_W;
			clsLh, clsSh: memSize = `CTRL_SZ_H;
			clsLb, clsSb: memSize = `CTRL_SZ_B;
			clsLwu: memSize = `CTRL_SZ_WU;
			clsLhu: memSize = `CTRL_SZ_HU;
			clsLbu: memSize = `CTRL_SZ_BU;
			default: memSize = `CTRL_SZ_NONE;
		endcase
	end

	// ALU op for the R and I execute cycle
	always_comb begin
		case (cls)
			clsSub: aluFunc = `CTRL_ALU_SUB;
			clsAnd: aluFunc = `CTRL_ALU_AND;
			clsSlt, clsSlti: aluFunc = `CTRL_ALU_CMP;
			default: aluFunc = `CTRL_ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

/* ctrlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer (
	input wire logic rst, // Clock
	input wire logic clk, // Async reset, active high
	input wire ctrlPkg::instrClass_t cls,
	output ctrlPkg::ctrlState_t state
);
	import ctrlPkg::*;

	ctrlState_t nextState;

	always_ff @(posedge rst or posedge clk) begin
		if (clk)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stDecode;
			stDecode: begin
				case (cls)
					clsAdd, clsSub, clsAnd, clsSlt: nextState = stAluExec;
					clsAddi, clsSlti: nextState = stImmExec;
					clsLd, clsLw, clsLh, clsLb, clsLwu, clsLhu, clsLbu:
						nextState = stLoadAddr;
					clsSd, clsSw, clsSh, clsSb: nextState = stStoreAddr;
					clsBeq: nextState = stBeq;
					clsBne: nextState = stBne;
					clsBge: nextState = stBge;
					clsBlt: nextState = stBlt;
					clsLui: nextState = stLui;
					clsJal: nextState = stJalLink;
					clsJalr: nextState = stJalrLink;
					clsNop: nextState = stNop;
					default: nextState = stExc1;
				endcase
			end
			stAluExec, stImmExec: nextState = stWriteBack;

			stLoadAddr: nextState = stLoadWait1;
			stLoadWait1: nextState = stLoadWait2;
			stLoadWait2: nextState = stLoadWrite;

			stStoreAddr: nextState = stStoreWrite;

			stJalLink: nextState = stJalJump;
			stJalrLink: nextState = stJalrJump;

			stExc1: nextState = stExc2;
			stExc2: nextState = stExc3;

			// Last cycle of every sequence
			default: nextState = stFetch;
		endcase
	end

endmodule

`default_nettype wire

/* ctrlOutputs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module ctrlOutputs (
	input wire ctrlPkg::ctrlState_t state,
	input wire ctrlPkg::memSize_t memSize,
	input wire ctrlPkg::aluOp_t aluFunc,
	input wire logic aluZero,
	input wire logic aluMenor,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic epcWrite,
	output logic irWrite,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadAluOut,
	output logic loadMemData,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::muxSel_t selA,
	output ctrlPkg::muxSel_t selB,
	output ctrlPkg::muxSel_t selMem,
	output ctrlPkg::muxSel_t selExc,
	output logic selAlu,
	output ctrlPkg::pcSel_t selPc,
	output ctrlPkg::memSize_t loadType,
	output ctrlPkg::memSize_t storeType
);
	import ctrlPkg::*;

	logic takeBranch;

	always_comb begin
		case (state)
			stBeq: takeBranch = aluZero;
			stBne: takeBranch = !aluZero;
			stBge: takeBranch = !aluMenor;
			stBlt: takeBranch = aluMenor;
			default: takeBranch = 1'b0;
		endcase
	end

	always_comb begin
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		epcWrite = 1'b0;
		irWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		loadRegA = 1'b0;
		loadRegB = 1'b0;
		loadAluOut = 1'b0;
		loadMemData = 1'b0;
		aluOp = `CTRL_ALU_PASS;
		selA = 3'd0;
		selB = 3'd0;
		selMem = 3'd0;
		selExc = 3'd0;
		selAlu = 1'b0;
		selPc = `CTRL_PC_SEQ;

		case (state)
			stFetch: begin // PC + 4 while the word is read
				irWrite = 1'b1;
				memRead = 1'b1;
				pcWrite = 1'b1;
				aluOp = `CTRL_ALU_ADD;
				selB = 3'd1;
				selMem = 3'd1;
			end
			stDecode: begin
				memRead = 1'b1;
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				loadAluOut = 1'b1; // Branch target
				aluOp = `CTRL_ALU_ADD;
				selB = 3'd3;
			end
			stAluExec, stImmExec: begin
				loadAluOut = 1'b1;
				aluOp = aluFunc;
				selA = 3'd1;
				selB = (state == stImmExec) ? 3'd2 : 3'd0;
				selAlu = (aluFunc == `CTRL_ALU_CMP); // slt result from the flag
			end
			stWriteBack: regWrite = 1'b1;

			stLoadAddr, stStoreAddr: begin
				loadAluOut = 1'b1;
				aluOp = `CTRL_ALU_ADD;
				selA = 3'd1;
				selB = 3'd2;
				selMem = 3'd1;
			end
			stLoadWait1, stLoadWait2: begin
				memRead = 1'b1;
				loadMemData = 1'b1;
			end
			stLoadWrite: begin
				regWrite = 1'b1;
				selMem = 3'd1;
			end
			stStoreWrite: memWrite = 1'b1;

			stBeq, stBne, stBge, stBlt: begin
				selA = 3'd1;
				selMem = 3'd1;
				aluOp = (state == stBeq || state == stBne) ? `CTRL_ALU_SUB : `CTRL_ALU_CMP;
				if (takeBranch) begin
					pcWrite = 1'b1;
					pcWriteCond = 1'b1;
					selPc = `CTRL_PC_TARGET;
				end
			end

			stLui: begin
				regWrite = 1'b1;
				selB = 3'd2;
				selMem = 3'd2;
			end

			stJalLink, stJalrLink: begin // rd <= PC, ALUOut <= jump target
				regWrite = 1'b1;
				loadAluOut = 1'b1;
				aluOp = `CTRL_ALU_ADD;
				selA = (state == stJalrLink) ? 3'd1 : 3'd0;
				selB = (state == stJalrLink) ? 3'd2 : 3'd3;
				selMem = 3'd7;
				selPc = `CTRL_PC_TARGET;
			end
			stJalJump, stJalrJump: begin
				pcWrite = 1'b1;
				aluOp = `CTRL_ALU_ADD;
				selA = 3'd1;
				selB = 3'd3;
				selPc = `CTRL_PC_TARGET;
			end

			stExc1: begin
				epcWrite = 1'b1; // EPC <= PC - 4
				aluOp = `CTRL_ALU_SUB;
				selB = 3'd1;
				selExc = 3'd1;
				pcWrite = 1'b1;
				selPc = `CTRL_PC_EXC;
			end
			stExc2: begin
				selExc = 3'd1;
				pcWrite = 1'b1;
				selPc = `CTRL_PC_EXC;
			end
			stExc3: begin
				pcWrite = 1'b1;
				selPc = `CTRL_PC_EXC;
			end

			default: ; // stReset and stNop drive nothing
		endcase
	end

	assign loadType = (state inside {stLoadAddr, stLoadWait1, stLoadWait2, stLoadWrite})
		? memSize : `CTRL_SZ_NONE;
	assign storeType = (state inside {stStoreAddr, stStoreWrite}) ? memSize : `CTRL_SZ_NONE;

endmodule

`default_nettype wire

/* ctrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlTop (
	input wire logic rst, // Clock
	input wire logic clk, // Async reset, active high
	input wire ctrlPkg::instr_t instr,
	input wire logic aluZero,
	input wire logic aluMenor,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic epcWrite,
	output logic irWrite,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadAluOut,
	output logic loadMemData,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::muxSel_t selA,
	output ctrlPkg::muxSel_t selB,
	output ctrlPkg::muxSel_t selMem,
	output ctrlPkg::muxSel_t selExc,
	output logic selAlu,
	output ctrlPkg::pcSel_t selPc,
	output ctrlPkg::memSize_t loadType,
	output ctrlPkg::memSize_t storeType
);
	import ctrlPkg::*;

	instrClass_t cls;
	memSize_t memSize;
	aluOp_t aluFunc;
	ctrlState_t state;

	instrDecoder i_instrDecoder (
		.instr(instr),
		.cls(cls),
		.memSize(memSize),
		.aluFunc(aluFunc)
	);

	ctrlSequencer i_ctrlSequencer (
		.rst(rst),
		.clk(clk),
		.cls(cls),
		.state(state)
	);

	ctrlOutputs i_ctrlOutputs (
		.state(state),
		.memSize(memSize),
		.aluFunc(aluFunc),
		.aluZero(aluZero),
		.aluMenor(aluMenor),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.epcWrite(epcWrite),
		.irWrite(irWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.loadRegA(loadRegA),
		.loadRegB(loadRegB),
		.loadAluOut(loadAluOut),
		.loadMemData(loadMemData),
		.aluOp(aluOp),
		.selA(selA),
		.selB(selB),
		.selMem(selMem),
		.selExc(selExc),
		.selAlu(selAlu),
		.selPc(selPc),
		.loadType(loadType),
		.storeType(storeType)
	);

endmodule

`default_nettype wire

/* ctrl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlProps (
	input wire logic rst, // Clock
	input wire logic clk, // Reset
	input wire logic memRead,
	input wire logic memWrite,
	input wire logic pcWrite,
	input wire logic pcWriteCond,
	input wire logic epcWrite,
	input wire logic irWrite
);

	memExclusive: assert property (@(posedge rst) disable iff (clk) !(memRead && memWrite))
		else $error("memRead and memWrite high together");

	condNeedsWrite: assert property (@(posedge rst) disable iff (clk) pcWriteCond |-> pcWrite)
		else $error("pcWriteCond without pcWrite");

	epcSingle: assert property (@(posedge rst) disable iff (clk) epcWrite |=> !epcWrite)
		else $error("epcWrite held for two cycles");

	// Reset state comes before the first fetch
	noEarlyFetch: assert property (@(posedge rst) $fell(clk) |-> !irWrite)
		else $error("irWrite high right after reset release");

endmodule

bind ctrlTop ctrlProps i_ctrlProps (
	.rst(rst),
	.clk(clk),
	.memRead(memRead),
	.memWrite(memWrite),
	.pcWrite(pcWrite),
	.pcWriteCond(pcWriteCond),
	.epcWrite(epcWrite),
	.irWrite(irWrite)
);

`default_nettype wire

/* ctrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module ctrlTb;
	import ctrlPkg::*;

	localparam int fieldsPerTest = 9;
	localparam int maxWords = 1 + 64 * fieldsPerTest;

	logic rst; // Clock
	logic clk; // Reset
	instr_t instr;
	logic aluZero;
	logic aluMenor;
	logic pcWrite;
	logic pcWriteCond;
	logic epcWrite;
	logic irWrite;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic loadRegA;
	logic loadRegB;
	logic loadAluOut;
	logic loadMemData;
	aluOp_t aluOp;
	muxSel_t selA;
	muxSel_t selB;
	muxSel_t selMem;
	muxSel_t selExc;
	logic selAlu;
	pcSel_t selPc;
	memSize_t loadType;
	memSize_t storeType;

	// Word 0 is the test count, then nine words per test
	logic [`CTRL_ILEN-1:0] tests [0:maxWords-1];
	int cycleLimit = 0;
	int cycleCount = 0;

	ctrlTop i_ctrlTop (
		.rst(rst),
		.clk(clk),
		.instr(instr),
		.aluZero(aluZero),
		.aluMenor(aluMenor),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.epcWrite(epcWrite),
		.irWrite(irWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.loadRegA(loadRegA),
		.loadRegB(loadRegB),
		.loadAluOut(loadAluOut),
		.loadMemData(loadMemData),
		.aluOp(aluOp),
		.selA(selA),
		.selB(selB),
		.selMem(selMem),
		.selExc(selExc),
		.selAlu(selAlu),
		.selPc(selPc),
		.loadType(loadType),
		.storeType(storeType)
	);

	initial begin
		rst = 1'b0;
		forever #4 rst = ~rst;
	end

	always @(posedge rst) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, irWrite never returned", cycleCount);
			$display("Verification failed");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, actual,
				expected);
			$display("Verification failed");
			$fatal(1, "value check failed");
		end
	endtask

	initial begin
		int numTests;
		int t;
		int base;
		int total;
		int cycles;
		int pcCount;
		int regCount;
		int epcCount;
		int condCount;
		int writeCount;
		int loadSeen;
		int storeSeen;

		clk = 1'b1;
		instr = '0;
		aluZero = 1'b0;
		aluMenor = 1'b0;

		$readmemh("ctrl_tests.txt", tests);
		numTests = int'(tests[0]);
		if (numTests < 1 || 1 + numTests * fieldsPerTest > maxWords) begin
			$display("Test file ctrl_tests.txt is missing, empty or too long");
			$display("Verification failed");
			$fatal(1, "no usable tests");
		end
		total = 0;
		for (t = 0; t < numTests; t++)
			total += int'(tests[1 + t * fieldsPerTest + 3]);
		cycleLimit = total + 20;

		repeat (2) begin // Nothing may fire while reset is held
			@(negedge rst);
			checkValue("enables in reset", int'({pcWrite, pcWriteCond, irWrite, memRead,
				memWrite, regWrite, epcWrite, loadRegA, loadRegB, loadAluOut, loadMemData,
				selAlu}), 0);
			checkValue("selects in reset", int'({aluOp, selA, selB, selMem, selExc, selPc,
				loadType, storeType}), 0);
		end
		clk = 1'b0;

		// Fetch sits between the first and second rising edge
		@(negedge rst);
		checkValue("irWrite after reset", int'(irWrite), 1);

		for (t = 0; t < numTests; t++) begin
			base = 1 + t * fieldsPerTest;
			cycles = 0;
			pcCount = 0;
			regCount = 0;
			epcCount = 0;
			condCount = 0;
			writeCount = 0;
			loadSeen = 0;
			storeSeen = 0;
			do begin
				if (pcWrite)
					pcCount++;
				if (regWrite)
					regCount++;
				if (epcWrite) begin
					epcCount++;
					checkValue("selExc with epcWrite", int'(selExc), 1);
					checkValue("selPc with epcWrite", int'(selPc), `CTRL_PC_EXC);
				end
				if (pcWriteCond) begin
					condCount++;
					checkValue("selPc with pcWriteCond", int'(selPc), `CTRL_PC_TARGET);
				end
				if (memWrite)
					writeCount++;
				if (loadType != '0)
					loadSeen = int'(loadType);
				if (storeType != '0)
					storeSeen = int'(storeType);
				if (cycles == 0) begin // Word for decode goes out during fetch
					checkValue("memRead in fetch", int'(memRead), 1);
					checkValue("pcWrite in fetch", int'(pcWrite), 1);
					checkValue("aluOp in fetch", int'(aluOp), `CTRL_ALU_ADD);
					checkValue("selB in fetch", int'(selB), 1);
					instr = tests[base];
					aluZero = tests[base + 1][0];
					aluMenor = tests[base + 2][0];
				end
				cycles++;
				@(negedge rst);
			end while (!irWrite);

			checkValue($sformatf("test %0d cycles", t), cycles, int'(tests[base + 3]));
			checkValue($sformatf("test %0d pcWrite", t), pcCount, int'(tests[base + 4]));
			checkValue($sformatf("test %0d regWrite", t), regCount, int'(tests[base + 5]));
			checkValue($sformatf("test %0d epcWrite", t), epcCount, int'(tests[base + 6]));
			checkValue($sformatf("test %0d loadType", t), loadSeen, int'(tests[base + 7]));
			checkValue($sformatf("test %0d storeType", t), storeSeen, int'(tests[base + 8]));
			// Only a taken branch writes the PC twice in three cycles
			checkValue($sformatf("test %0d pcWriteCond", t), condCount,
				(tests[base + 3] == 3 && tests[base + 4] == 2) ? 1 : 0);
			checkValue($sformatf("test %0d memWrite", t), writeCount,
				(tests[base + 8] != 0) ? 1 : 0);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* ctrl_tests.txt */
// Columns: instr aluZero aluMenor cycles pcWrite regWrite epcWrite loadType storeType
// All values hex, the first word is the number of tests
1f
003100B3 0 0 4 1 1 0 0 0 // add
403100B3 0 0 4 1 1 0 0 0 // sub
003170B3 0 0 4 1 1 0 0 0 // and
003120B3 0 0 4 1 1 0 0 0 // slt
00510093 0 0 4 1 1 0 0 0 // addi
00512093 0 0 4 1 1 0 0 0 // slti
00810083 0 0 6 1 1 0 4 0 // lb
00811083 0 0 6 1 1 0 3 0 // lh
00812083 0 0 6 1 1 0 2 0 // lw
00813083 0 0 6 1 1 0 1 0 // ld
00814083 0 0 6 1 1 0 7 0 // lbu
00815083 0 0 6 1 1 0 6 0 // lhu
00816083 0 0 6 1 1 0 5 0 // lwu
00310023 0 0 4 1 0 0 0 4 // sb
00311023 0 0 4 1 0 0 0 3 // sh
00312023 0 0 4 1 0 0 0 2 // sw
00317023 0 0 4 1 0 0 0 1 // sd
00310063 1 0 3 2 0 0 0 0 // beq taken
00310063 0 1 3 1 0 0 0 0 // beq not taken
00311067 0 0 3 2 0 0 0 0 // bne taken
00311067 1 0 3 1 0 0 0 0 // bne not taken
00315067 0 0 3 2 0 0 0 0 // bge taken
00315067 0 1 3 1 0 0 0 0 // bge not taken
00314067 0 1 3 2 0 0 0 0 // blt taken
00314067 1 0 3 1 0 0 0 0 // blt not taken
123450B7 0 0 3 1 1 0 0 0 // lui
008000EF 0 0 4 2 1 0 0 0 // jal
000100E7 0 0 4 2 1 0 0 0 // jalr
00000000 0 0 3 1 0 0 0 0 // nop
0000007F 0 0 5 4 0 1 0 0 // unknown opcode
00313067 0 0 5 4 0 1 0 0 // unknown funct3 under the jalr opcode

/* list.f */
+incdir+.
ctrlPkg.sv
instrDecoder.sv
ctrlSequencer.sv
ctrlOutputs.sv
ctrlTop.sv
ctrl_props.sv
ctrlTb.sv

/* Makefile */
TOP = ctrlTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o simv

run: compile
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
